// ==== Bender.yml ====
package:
  name: mem_bus_node

sources:
  - hw/membus_pkg.sv
  - hw/memarray_pkg.sv
  - hw/mem_req_if.sv
  - hw/bus_sequencer.sv
  - hw/request_latches.sv
  - hw/mem_port.sv
  - hw/mem_bank.sv
  - hw/mem_bus_node.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mem_bus_node.sv

// ==== hw/bus_sequencer.sv ====
// Bus handshake FSM: slave receive, bus request and master return of a block.
// bg must stay high until the node drives its control lines.
module bus_sequencer
   import membus_pkg::*;
(
   input  logic              bus_clk,
   input  logic              arst_n,
   input  logic [DEST_W-1:0] dest_in,
   input  logic              bus_rw_in,
   input  logic              bg,
   input  logic              ack_in,
   input  logic              wr_full,
   input  logic              ret_pending,
   output logic              ack_out,
   output logic              br,
   output logic              bus_ctrl_oe,
   output logic              bus_d_oe,
   output logic              accept,
   output logic              beat_en,
   output logic [BEAT_W-1:0] beat_idx,
   output logic              ret_done
);

   seq_state_t        state_q;
   seq_state_t        state_d;
   logic [BEAT_W-1:0] beat_cnt_q;
   logic              bus_claimed;
   logic              grant;
   logic              last_beat;

   assign bus_claimed = |dest_in;

   // A granted return wins over a requester waiting for ack
   assign grant     = ret_pending && bg;
   assign last_beat = (beat_cnt_q == BEAT_W'(BEATS - 1));

   ////////////////////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         IDLE:
         begin
            if (grant)
               state_d = MSTR_CTRL;
            else if (ack_out && bus_rw_in)
               state_d = SLV_RX;
            else if (ret_pending && !bus_claimed)
               state_d = BUS_REQ;
         end
         SLV_RX:
            if (last_beat)
               state_d = IDLE;
         BUS_REQ:
         begin
            // Another requester got the bus first, serve it
            if (grant)
               state_d = MSTR_CTRL;
            else if (bus_claimed)
               state_d = IDLE;
         end
         MSTR_CTRL:
            if (ack_in)
               state_d = MSTR_DATA;
         MSTR_DATA:
            if (last_beat)
               state_d = IDLE;
         default:
            state_d = IDLE;
      endcase
   end

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   // Beat counter, runs only while data moves on the bus
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
         beat_cnt_q <= '0;
      else if (state_q == SLV_RX || state_q == MSTR_DATA)
         beat_cnt_q <= beat_cnt_q + 1'b1;
      else
         beat_cnt_q <= '0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////////////////////////////////////////

   assign ack_out     = (state_q == IDLE) && bus_claimed && !wr_full && !grant;
   assign accept      = ack_out;
   assign beat_en     = (state_q == SLV_RX);
   assign beat_idx    = beat_cnt_q;
   assign bus_ctrl_oe = (state_q == MSTR_CTRL);
   assign bus_d_oe    = (state_q == MSTR_DATA);
   assign ret_done    = (state_q == MSTR_DATA) && last_beat;
   assign br          = ret_pending && !ret_done;

   // The write latch fills on ack, so a second ack cannot follow directly
   a_ack_single: assert property (@(posedge bus_clk) disable iff (!arst_n)
      ack_out |=> !ack_out);

   // Returned data stays held in the latches until the last beat
   a_data_held: assert property (@(posedge bus_clk) disable iff (!arst_n)
      bus_d_oe |-> ret_pending);

endmodule

// ==== hw/mem_bank.sv ====
// 256 x 256-bit line memory, byte-enable writes, one-cycle registered read.
// Contents start as zero; read during write returns the old line.
module mem_bank
   import memarray_pkg::*;
(
   input  logic                  bus_clk,
   input  logic                  bank_en,
   input  logic                  bank_we,
   input  logic [LINE_IDX_W-1:0] bank_line,
   input  logic [BE_W-1:0]       bank_be,
   input  logic [LINE_W-1:0]     bank_wdata,
   output logic [LINE_W-1:0]     bank_rdata
);

   logic [LINE_W-1:0] mem_q [LINES];

   initial
   begin
      for (int i = 0; i < LINES; i++)
         mem_q[i] = '0;
   end

   always_ff @(posedge bus_clk)
   begin
      if (bank_en)
      begin
         if (bank_we)
         begin
            for (int b = 0; b < BE_W; b++)
            begin
               if (bank_be[b])
                  mem_q[bank_line][b*8 +: 8] <= bank_wdata[b*8 +: 8];
            end
         end
         bank_rdata <= mem_q[bank_line];
      end
   end

endmodule

// ==== hw/mem_bus_node.sv ====
// Memory node on the split bus; each tristate line is split into in, out and enable.
// The node returns blocks to ic and dc only, DMA reads are dropped after access.
module mem_bus_node
   import membus_pkg::*, memarray_pkg::*;
(
   input  logic              bus_clk,
   input  logic              arst_n,
   input  logic [ADDR_W-1:0] bus_a_in,
   output logic [ADDR_W-1:0] bus_a_out,
   input  logic [SIZE_W-1:0] bus_size_in,
   output logic [SIZE_W-1:0] bus_size_out,
   input  logic              bus_rw_in,
   output logic              bus_rw_out,
   input  logic [BUS_W-1:0]  bus_d_in,
   output logic [BUS_W-1:0]  bus_d_out,
   output logic              bus_ctrl_oe,
   output logic              bus_d_oe,
   input  logic [DEST_W-1:0] dest_in,
   output logic              br,
   input  logic              bg,
   output logic              ack_out,
   input  logic              ack_in,
   output logic              dest_out_ic,
   output logic              dest_out_dc
);

   logic                  accept;
   logic                  beat_en;
   logic [BEAT_W-1:0]     beat_idx;
   logic                  ret_done;
   logic                  wr_full;
   logic                  ret_pending;
   src_t                  ret_src;
   logic                  bank_en;
   logic                  bank_we;
   logic [LINE_IDX_W-1:0] bank_line;
   logic [BE_W-1:0]       bank_be;
   logic [LINE_W-1:0]     bank_wdata;
   logic [LINE_W-1:0]     bank_rdata;

   mem_req_if mem_req ();

   // The node only ever masters a 16-byte write back to a cache
   assign bus_size_out = SIZE_BLOCK;
   assign bus_rw_out   = 1'b1;
   assign dest_out_ic  = bus_ctrl_oe && (ret_src == SRC_IC);
   assign dest_out_dc  = bus_ctrl_oe && (ret_src == SRC_DC);

   bus_sequencer bus_sequencer_inst (
      .bus_clk, .arst_n, .dest_in, .bus_rw_in, .bg, .ack_in, .wr_full, .ret_pending,
      .ack_out, .br, .bus_ctrl_oe, .bus_d_oe, .accept, .beat_en, .beat_idx, .ret_done
   );

   request_latches request_latches_inst (
      .bus_clk, .arst_n, .accept, .beat_en, .beat_idx, .bus_a_in,
      .bus_size_in(bus_size_in[SIZE_CODE_W-1:0]), .bus_rw_in, .bus_d_in, .dest_in,
      .ret_done, .req(mem_req.latch), .wr_full, .ret_pending,
      .ret_addr(bus_a_out), .ret_src, .ret_word(bus_d_out)
   );

   mem_port mem_port_inst (
      .bus_clk, .arst_n, .req(mem_req.port), .bank_en, .bank_we, .bank_line,
      .bank_be, .bank_wdata, .bank_rdata
   );

   mem_bank mem_bank_inst (
      .bus_clk, .bank_en, .bank_we, .bank_line, .bank_be, .bank_wdata, .bank_rdata
   );

endmodule

// ==== hw/mem_port.sv ====
// Memory port: access timer, write alignment and byte enables, read half select.
// Write data arrives low-aligned and is moved to the address offset here.
module mem_port
   import membus_pkg::*, memarray_pkg::*;
(
   input  logic                  bus_clk,
   input  logic                  arst_n,
   mem_req_if.port               req,
   output logic                  bank_en,
   output logic                  bank_we,
   output logic [LINE_IDX_W-1:0] bank_line,
   output logic [BE_W-1:0]       bank_be,
   output logic [LINE_W-1:0]     bank_wdata,
   input  logic [LINE_W-1:0]     bank_rdata
);

   logic [TIMER_W-1:0]         timer_q;
   logic [OFFSET_W:0]          nbytes;
   logic [BLOCK_BYTES:0]       mask;
   logic [BLOCK_BYTES-1:0]     be_half;
   logic [BLOCK_W-1:0]         shifted;

   ////////////////////////////////////////////////////////////////////////////
   // Access timer
   ////////////////////////////////////////////////////////////////////////////

   // Restarts after done so a back-to-back access gets its full time
   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
         timer_q <= '0;
      else if (!req.valid || req.done)
         timer_q <= '0;
      else
         timer_q <= timer_q + 1'b1;
   end

   assign req.done = req.valid && (timer_q == TIMER_W'(ACCESS_CYC));

   // Bank is hit one cycle early to cover its registered read
   assign bank_en   = req.valid && (timer_q == TIMER_W'(ACCESS_CYC - 1));
   assign bank_we   = bank_en && (req.kind == ACC_WRITE);
   assign bank_line = req.addr[LINE_LSB +: LINE_IDX_W];

   ////////////////////////////////////////////////////////////////////////////
   // Write alignment
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      // Byte count is 2**size, clipped to the block
      if (req.size >= SIZE_CODE_BLOCK)
         nbytes = (OFFSET_W + 1)'(BLOCK_BYTES);
      else
         nbytes = (OFFSET_W + 1)'(1) << req.size;
      mask    = ((BLOCK_BYTES + 1)'(1) << nbytes) - 1'b1;
      be_half = BLOCK_BYTES'(mask << req.addr[OFFSET_W-1:0]);
      shifted = req.wdata << {req.addr[OFFSET_W-1:0], 3'b000};
   end

   assign bank_wdata = {shifted, shifted};
   assign bank_be    = req.addr[HALF_BIT] ? {be_half, {BLOCK_BYTES{1'b0}}}
                                          : {{BLOCK_BYTES{1'b0}}, be_half};

   // Reads return the whole aligned block from the addressed half
   assign req.rdata = req.addr[HALF_BIT] ? bank_rdata[LINE_W-1:BLOCK_W]
                                         : bank_rdata[BLOCK_W-1:0];

endmodule

// ==== hw/mem_req_if.sv ====
// One memory access presented by the latch pipeline to the memory port.
// done pulses once per access; rdata is valid only with done on reads.
interface mem_req_if
   import membus_pkg::*, memarray_pkg::*;
();

   logic                   valid;
   acc_kind_t              kind;
   logic [ADDR_W-1:0]      addr;
   logic [SIZE_CODE_W-1:0] size;
   src_t                   src;
   logic [BLOCK_W-1:0]     wdata;

   // Answer from the port
   logic                   done;
   logic [BLOCK_W-1:0]     rdata;

   modport latch (
      output valid, kind, addr, size, src, wdata,
      input  done, rdata
   );

   modport port (
      input  valid, kind, addr, size, src, wdata,
      output done, rdata
   );

endinterface

// ==== hw/memarray_pkg.sv ====
// Bank-side constants for the 256-bit line memory.
// Only address bits 12 to 4 reach the bank, higher bits alias.
package memarray_pkg;

   // Line geometry
   localparam int LINE_W     = 256;
   localparam int LINES      = 256;
   localparam int LINE_IDX_W = $clog2(LINES);
   localparam int BE_W       = LINE_W / 8;

   // Address bit picking the 128-bit half, and the lowest line index bit
   localparam int HALF_BIT = 4;
   localparam int LINE_LSB = 5;

   // Fixed access time in bus clocks
   localparam int ACCESS_CYC = 4;
   localparam int TIMER_W    = $clog2(ACCESS_CYC + 1);

   typedef enum logic {
      ACC_READ,
      ACC_WRITE
   } acc_kind_t;

endpackage

// ==== hw/membus_pkg.sv ====
// Bus-side constants and types for the memory node on the split-transaction bus.
// Size codes above 4 are treated as a full 16-byte block.
package membus_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Bus geometry
   ////////////////////////////////////////////////////////////////////////////

   localparam int BUS_W       = 32;
   localparam int ADDR_W      = 16;
   localparam int BLOCK_BYTES = 16;
   localparam int BLOCK_W     = BLOCK_BYTES * 8;
   localparam int BEATS       = BLOCK_W / BUS_W;
   localparam int BEAT_W      = $clog2(BEATS);
   localparam int OFFSET_W    = $clog2(BLOCK_BYTES);

   // Size field, requesters place a log2 byte count in the low bits
   localparam int SIZE_W      = 12;
   localparam int SIZE_CODE_W = 3;
   localparam logic [SIZE_CODE_W-1:0] SIZE_CODE_BLOCK = 3'd4;

   // Value driven on the size lines when returning a block
   localparam logic [SIZE_W-1:0] SIZE_BLOCK = 12'h010;

   ////////////////////////////////////////////////////////////////////////////
   // Requesters
   ////////////////////////////////////////////////////////////////////////////

   // Bit positions in the one-hot destination lines
   localparam int DEST_W   = 3;
   localparam int DEST_IC  = 0;
   localparam int DEST_DC  = 1;
   localparam int DEST_DMA = 2;

   typedef enum logic [1:0] {
      SRC_IC,
      SRC_DC,
      SRC_DMA
   } src_t;

   // Sequencer states
   typedef enum logic [2:0] {
      IDLE,
      SLV_RX,
      BUS_REQ,
      MSTR_CTRL,
      MSTR_DATA
   } seq_state_t;

endpackage

// ==== hw/request_latches.sv ====
// Two-stage request pipeline: write latch from the bus, read latch at the bank.
// The read latch keeps a read block until its return completes.
module request_latches
   import membus_pkg::*, memarray_pkg::*;
(
   input  logic                   bus_clk,
   input  logic                   arst_n,
   input  logic                   accept,
   input  logic                   beat_en,
   input  logic [BEAT_W-1:0]      beat_idx,
   input  logic [ADDR_W-1:0]      bus_a_in,
   input  logic [SIZE_CODE_W-1:0] bus_size_in,
   input  logic                   bus_rw_in,
   input  logic [BUS_W-1:0]       bus_d_in,
   input  logic [DEST_W-1:0]      dest_in,
   input  logic                   ret_done,
   mem_req_if.latch               req,
   output logic                   wr_full,
   output logic                   ret_pending,
   output logic [ADDR_W-1:0]      ret_addr,
   output src_t                   ret_src,
   output logic [BUS_W-1:0]       ret_word
);

   logic                   wr_valid_q;
   logic                   rd_valid_q;
   logic                   served_q;
   acc_kind_t              wr_kind_q;
   acc_kind_t              rd_kind_q;
   logic [ADDR_W-1:0]      wr_addr_q;
   logic [ADDR_W-1:0]      rd_addr_q;
   logic [SIZE_CODE_W-1:0] wr_size_q;
   logic [SIZE_CODE_W-1:0] rd_size_q;
   src_t                   wr_src_q;
   src_t                   rd_src_q;
   logic [BLOCK_W-1:0]     wr_data_q;
   logic [BLOCK_W-1:0]     rd_data_q;
   src_t                   bus_src;
   logic                   ld_wr;
   logic                   ld_rd;
   logic                   clr_rd;

   assign bus_src = dest_in[DEST_IC] ? SRC_IC : (dest_in[DEST_DC] ? SRC_DC : SRC_DMA);

   // Reads are complete at ack, writes after their last beat
   assign ld_wr  = (accept && !bus_rw_in) ||
                   (beat_en && beat_idx == BEAT_W'(BEATS - 1));
   // Writes and DMA reads leave at done, cache reads after their return
   assign clr_rd = (req.done && (rd_kind_q == ACC_WRITE || rd_src_q == SRC_DMA)) ||
                   ret_done;
   assign ld_rd  = wr_valid_q && (!rd_valid_q || clr_rd);

   always_ff @(posedge bus_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_valid_q <= 1'b0;
         rd_valid_q <= 1'b0;
         served_q   <= 1'b0;
      end
      else
      begin
         if (ld_wr)
            wr_valid_q <= 1'b1;
         else if (ld_rd)
            wr_valid_q <= 1'b0;
         if (ld_rd)
            rd_valid_q <= 1'b1;
         else if (clr_rd)
            rd_valid_q <= 1'b0;
         // Marks a finished bank access so it is not presented again
         if (ld_rd)
            served_q <= 1'b0;
         else if (req.done)
            served_q <= 1'b1;
      end
   end

   always_ff @(posedge bus_clk)
   begin
      if (accept)
      begin
         wr_kind_q <= bus_rw_in ? ACC_WRITE : ACC_READ;
         wr_addr_q <= bus_a_in;
         wr_size_q <= bus_size_in;
         wr_src_q  <= bus_src;
      end
      if (beat_en)
         wr_data_q[beat_idx*BUS_W +: BUS_W] <= bus_d_in;
      if (ld_rd)
      begin
         rd_kind_q <= wr_kind_q;
         rd_addr_q <= wr_addr_q;
         rd_size_q <= wr_size_q;
         rd_src_q  <= wr_src_q;
         rd_data_q <= wr_data_q;
      end
      else if (req.done && rd_kind_q == ACC_READ)
         rd_data_q <= req.rdata;
   end

   assign req.valid = rd_valid_q && !served_q;
   assign req.kind  = rd_kind_q;
   assign req.addr  = rd_addr_q;
   assign req.size  = rd_size_q;
   assign req.src   = rd_src_q;
   assign req.wdata = rd_data_q;

   assign wr_full     = wr_valid_q;
   assign ret_pending = rd_valid_q && served_q;
   assign ret_addr    = {rd_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
   assign ret_src     = rd_src_q;
   assign ret_word    = rd_data_q[beat_idx*BUS_W +: BUS_W];

   // A block waiting for return is never replaced before its last beat
   a_rd_kept: assert property (@(posedge bus_clk) disable iff (!arst_n)
      ret_pending && !ret_done |=> ret_pending && $stable(rd_addr_q));

endmodule

// ==== sim.f ====
+incdir+sim
hw/membus_pkg.sv
hw/memarray_pkg.sv
hw/mem_req_if.sv
hw/bus_sequencer.sv
hw/request_latches.sv
hw/mem_port.sv
hw/mem_bank.sv
hw/mem_bus_node.sv
sim/tb_mem_bus_node.sv

// ==== sim/bus_agent.svh ====
// Requester and arbiter tasks, included inside the testbench module.
// All drives happen on the rising edge, all samples on the falling edge.
`ifndef BUS_AGENT_SVH
`define BUS_AGENT_SVH

// Drives the control lines of a requester and waits for ack_out
task automatic claim_bus(input src_t src, input logic [ADDR_W-1:0] addr,
                         input int size_code, input logic rw);
   logic [DEST_W-1:0] d;
   d = '0;
   d[int'(src)] = 1'b1;
   @(posedge bus_clk);
   bus_a_in    <= addr;
   bus_size_in <= SIZE_W'(size_code);
   bus_rw_in   <= rw;
   dest_in     <= d;
   do
      @(negedge bus_clk);
   while (!ack_out);
endtask

task automatic issue_write(input src_t src, input logic [ADDR_W-1:0] addr,
                           input int size_code, input logic [BLOCK_W-1:0] data);
   claim_bus(src, addr, size_code, 1'b1);
   @(posedge bus_clk);
   dest_in   <= '0;
   bus_rw_in <= 1'b0;
   bus_d_in  <= data[BUS_W-1:0];
   // Remaining beats, lowest word first
   for (int i = 1; i < BEATS; i++)
   begin
      @(posedge bus_clk);
      bus_d_in <= data[i*BUS_W +: BUS_W];
   end
   model[addr[12:4]] = merge_block(model[addr[12:4]], addr[3:0], size_code, data);
endtask

task automatic issue_read(input src_t src, input logic [ADDR_W-1:0] addr);
   claim_bus(src, addr, 4, 1'b0);
   @(posedge bus_clk);
   dest_in <= '0;
   if (src != SRC_DMA)
      exp_q.push_back(model[addr[12:4]]);
endtask

// Holds a request on the bus and expects no ack for the whole time
task automatic hold_without_ack(input src_t src, input logic [ADDR_W-1:0] addr,
                                input int cycles);
   @(posedge bus_clk);
   bus_a_in  <= addr;
   bus_rw_in <= 1'b0;
   dest_in   <= DEST_W'(1) << int'(src);
   for (int i = 0; i < cycles; i++)
   begin
      @(negedge bus_clk);
      if (ack_out)
      begin
         $display("Request acknowledged while both latches were full");
         errors++;
      end
   end
   @(posedge bus_clk);
   dest_in <= '0;
endtask

// Plays the arbiter for one return and collects its four beats
task automatic serve_return(input src_t src, input logic [ADDR_W-1:0] addr,
                            input int bg_delay, input int ack_delay);
   logic [BLOCK_W-1:0] blk;
   logic [1:0]         exp_dest;
   exp_dest = (src == SRC_IC) ? 2'b01 : 2'b10;
   do
      @(negedge bus_clk);
   while (!br);
   repeat (bg_delay) @(posedge bus_clk);
   @(posedge bus_clk);
   bg <= 1'b1;
   do
      @(negedge bus_clk);
   while (!bus_ctrl_oe);
   check_value("bus_a_out", bus_a_out, {addr[ADDR_W-1:4], 4'h0});
   check_value("bus_size_out", bus_size_out, 16);
   check_value("bus_rw_out", bus_rw_out, 1);
   check_value("dest_out", {dest_out_dc, dest_out_ic}, exp_dest);
   @(posedge bus_clk);
   bg <= 1'b0;
   repeat (ack_delay) @(posedge bus_clk);
   ack_in <= 1'b1;
   @(posedge bus_clk);
   ack_in <= 1'b0;
   for (int i = 0; i < BEATS; i++)
   begin
      @(negedge bus_clk);
      if (!bus_d_oe)
      begin
         $display("Data enable low during return beat %0d", i);
         errors++;
      end
      blk[i*BUS_W +: BUS_W] = bus_d_out;
   end
   check_value("br", br, 0);
   got_q.push_back(blk);
endtask

// Nothing may be returned or requested for a while
task automatic expect_quiet(input int cycles);
   for (int i = 0; i < cycles; i++)
   begin
      @(negedge bus_clk);
      if (br || bus_d_oe || dest_out_ic || dest_out_dc)
      begin
         $display("Node started a return that nobody asked for");
         errors++;
      end
   end
endtask

`endif

// ==== sim/tb_mem_bus_node.sv ====
// Testbench for the memory node; the testbench plays every requester and the arbiter.
// Only address bits 12 to 4 select a block in the reference model.
module tb_mem_bus_node
   import membus_pkg::*, memarray_pkg::*;
();

   localparam int N_REQ       = 60;
   localparam int TIMEOUT_CYC = N_REQ * 200 + 500;

   logic              bus_clk;
   logic              arst_n;
   logic [ADDR_W-1:0] bus_a_in;
   logic [ADDR_W-1:0] bus_a_out;
   logic [SIZE_W-1:0] bus_size_in;
   logic [SIZE_W-1:0] bus_size_out;
   logic              bus_rw_in;
   logic              bus_rw_out;
   logic [BUS_W-1:0]  bus_d_in;
   logic [BUS_W-1:0]  bus_d_out;
   logic              bus_ctrl_oe;
   logic              bus_d_oe;
   logic [DEST_W-1:0] dest_in;
   logic              br;
   logic              bg;
   logic              ack_out;
   logic              ack_in;
   logic              dest_out_ic;
   logic              dest_out_dc;

   logic [BLOCK_W-1:0] model [512];
   logic [BLOCK_W-1:0] exp_q [$];
   logic [BLOCK_W-1:0] got_q [$];
   int                 errors;
   int                 checks;
   int                 errs_at_start;
   integer             seed;

   mem_bus_node mem_bus_node_inst (.*);

   initial
   begin
      bus_clk = 1'b0;
      forever #5 bus_clk = ~bus_clk;
   end

   initial
   begin
      repeat (TIMEOUT_CYC) @(posedge bus_clk);
      $display("Watchdog expired after %0d cycles, run stopped", TIMEOUT_CYC);
      $display("STATUS: FAIL");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model and checking
   ////////////////////////////////////////////////////////////////////////////

   // Size code n writes 2**n low bytes of data at the offset, clipped at 16
   function automatic logic [BLOCK_W-1:0] merge_block(input logic [BLOCK_W-1:0] old,
      input logic [3:0] off, input int size_code, input logic [BLOCK_W-1:0] data);
      logic [BLOCK_W-1:0] blk;
      int                 nbytes;
      blk    = old;
      nbytes = (size_code >= 4) ? BLOCK_BYTES : (1 << size_code);
      for (int j = 0; j < nbytes; j++)
      begin
         if (int'(off) + j < BLOCK_BYTES)
            blk[(int'(off) + j)*8 +: 8] = data[j*8 +: 8];
      end
      return blk;
   endfunction

   function automatic logic [BLOCK_W-1:0] rand_block();
      return {$random(seed), $random(seed), $random(seed), $random(seed)};
   endfunction

   task automatic check_value(input string name, input logic [BLOCK_W-1:0] got,
                              input logic [BLOCK_W-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name);
      // Blocks of this test are compared before its line is printed
      while (got_q.size() != 0)
         @(posedge bus_clk);
      $display("Test %0d %s: done, %0d errors", num, name, errors - errs_at_start);
      errs_at_start = errors;
   endtask

   `include "bus_agent.svh"

   // Returned blocks are compared in order of issue
   initial
   begin
      forever
      begin
         @(posedge bus_clk);
         while (got_q.size() != 0)
            check_value("return block", got_q.pop_front(), exp_q.pop_front());
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      int                 sizes [6];
      int                 offs [6];
      logic [31:0]        r;
      logic [ADDR_W-1:0]  a;
      src_t               s;
      arst_n        = 1'b0;
      bus_a_in      = '0;
      bus_size_in   = '0;
      bus_rw_in     = 1'b0;
      bus_d_in      = '0;
      dest_in       = '0;
      bg            = 1'b0;
      ack_in        = 1'b0;
      errors        = 0;
      checks        = 0;
      errs_at_start = 0;
      seed          = 32'h0443b808;
      sizes         = '{0, 1, 2, 3, 3, 4};
      offs          = '{5, 2, 8, 4, 13, 9};
      for (int i = 0; i < 512; i++)
         model[i] = '0;
      repeat (5) @(posedge bus_clk);
      arst_n <= 1'b1;
      @(posedge bus_clk);

      @(negedge bus_clk);
      check_value("br", br, 0);
      check_value("ack_out", ack_out, 0);
      check_value("bus_ctrl_oe", bus_ctrl_oe, 0);
      check_value("bus_d_oe", bus_d_oe, 0);
      check_value("dest_out", {dest_out_dc, dest_out_ic}, 0);
      report_test(1, "reset values");

      issue_write(SRC_DC, 16'h0120, 4, rand_block());
      issue_read(SRC_DC, 16'h0124);
      serve_return(SRC_DC, 16'h0124, 0, 0);
      report_test(2, "block write and read");

      issue_write(SRC_DC, 16'h0340, 4, rand_block());
      for (int i = 0; i < 6; i++)
         issue_write(SRC_DC, 16'h0340 + offs[i], sizes[i], rand_block());
      issue_read(SRC_DC, 16'h0340);
      serve_return(SRC_DC, 16'h0340, 1, 2);
      report_test(3, "partial writes");

      issue_write(SRC_IC, 16'h1a50, 4, rand_block());
      issue_read(SRC_IC, 16'h1a50);
      serve_return(SRC_IC, 16'h1a50, 2, 1);
      issue_read(SRC_DMA, 16'h1a50);
      expect_quiet(3 * ACCESS_CYC + 10);
      report_test(4, "ic and dma reads");

      // Pending return blocks the read latch and the write then fills the write latch
      issue_read(SRC_DC, 16'h0120);
      issue_write(SRC_DC, 16'h0780, 4, rand_block());
      hold_without_ack(SRC_IC, 16'h0780, 20);
      serve_return(SRC_DC, 16'h0120, 0, 0);
      issue_read(SRC_IC, 16'h0780);
      serve_return(SRC_IC, 16'h0780, 0, 3);
      report_test(5, "pipelining and back-pressure");

      for (int n = 0; n < 40; n++)
      begin
         r = $random(seed);
         a = r[15:0];
         s = src_t'(r[17:16] % 3);
         if (r[18])
            issue_write(s, a, int'(r[22:20]) % 5, rand_block());
         else
         begin
            issue_read(s, a);
            if (s != SRC_DMA)
               serve_return(s, a, int'(r[25:24]), int'(r[27:26]));
         end
      end
      report_test(6, "random traffic");

      $display("Tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule
